//--- Makefile
# Verilator flow for the radio core testbench

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module radio_tb

obj_dir/Vradio_tb: tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -f tb.f --top-module radio_tb -o Vradio_tb

sim: obj_dir/Vradio_tb
	./obj_dir/Vradio_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb.f
verilog/radio_regs_pkg.sv
verilog/radio_io_pkg.sv
verilog/radio_ctrl.sv
verilog/gpio_atr.sv
verilog/timekeeper.sv
verilog/spi_core.sv
verilog/radio_core.sv
verif/radio_sva.sv
verif/radio_tb.sv

//--- verif/radio_sva.sv
// ####################
// Radio core assertions
// Sync pulse, chip selects and time counting
// ####################
module radio_sva (
   input logic                                radio_clk,
   input logic                                rst_n,
   input logic                                sync_dacs,
   input logic                                spi_ready,
   input logic [radio_io_pkg::sen_w-1:0]      sen,
   input logic [radio_io_pkg::time_w-1:0]     vita_time,
   input logic                                time_wr,
   input logic                                pps
);
   timeunit 1ns;
   timeprecision 100ps;

   a_sync_single: assert property (@(posedge radio_clk) disable iff (!rst_n)
      sync_dacs |=> !sync_dacs)
      else $error("sync_dacs stayed high for two cycles");

   a_sen_idle: assert property (@(posedge radio_clk) disable iff (!rst_n)
      spi_ready |-> (sen == '1))
      else $error("chip select active while SPI is idle");

   // A PPS edge takes effect three samples after pps was seen high
   a_time_count: assert property (@(posedge radio_clk) disable iff (!rst_n)
      ($past(rst_n) && !$past(time_wr) && !$past(pps, 3))
         |-> (vita_time == $past(vita_time) + 64'd1))
      else $error("vita_time did not count by one");

endmodule

bind radio_core radio_sva sva0 (
   .radio_clk(radio_clk), .rst_n(rst_n), .sync_dacs(sync_dacs),
   .spi_ready(spi_ready), .sen(sen), .vita_time(vita_time),
   .time_wr(time_wr), .pps(pps)
);

//--- verif/radio_tb.sv
// ####################
// Radio core testbench
// Register, ATR, time and SPI checks
// ####################
module radio_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic        radio_clk, rst_n, set_stb, pps, run_rx, run_tx, miso;
   logic [7:0]  set_addr;
   logic [31:0] set_data, db_gpio_in, db_gpio_out, db_gpio_ddr;
   logic [63:0] rb_data, vita_time;
   logic [2:0]  leds;
   logic [7:0]  misc_outs, sen;
   logic        spi_ready, sync_dacs, sclk, mosi;

   logic [31:0] lfsr = 32'hc3a5;
   int          errors = 0;
   int          ops = 0;
   logic [63:0] exp_rb;
   bit          exp_chk = 0;
   // Model of the control registers
   logic [31:0] m_test = '0, m_db_in = '0;
   logic [7:0]  m_misc = '0;
   logic        m_lb = 1'b0;

   assign miso = mosi;

   radio_core dut0 (.*);

   initial begin
      radio_clk = 1'b0;
      forever #10 radio_clk = ~radio_clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] get_rand(input int n);
      logic        fb;
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [63:0] ref_rb(input logic [2:0] code);
      case (code)
         3'd0:    return {32'd0, m_db_in};
         3'd3:    return {31'd0, m_lb, m_test};
         3'd4:    return {55'd0, m_lb, m_misc};
         3'd5:    return {62'd0, run_tx, run_rx};
         3'd6:    return {32'd0, radio_regs_pkg::radio_num};
         default: return 64'd0;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Called on a falling edge, returns on the next one
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      ops++;
      @(negedge radio_clk);
      set_stb  = 1'b0;
   endtask

   task automatic select_rb(input logic [2:0] code, input logic [63:0] exp, input bit chk);
      exp_rb  = exp;
      exp_chk = chk;
      write_reg(radio_regs_pkg::sr_readback, {29'd0, code});
   endtask

   // Compare after each selector write
   always @(posedge radio_clk) begin
      if (rst_n && set_stb && set_addr == radio_regs_pkg::sr_readback && exp_chk) begin
         #5;
         check_val("rb_data", rb_data, exp_rb);
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(posedge radio_clk);
         cycles++;
         if (cycles > 200 * (ops + 1)) begin
            $display("timeout: the DUT stopped making progress");
            $display("test failed");
            $finish;
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r, hi, lo, div, len, mask, edge_s, data, lmask;
      logic [31:0] db_w[4];
      logic [2:0]  led_w[4];
      logic [63:0] t0;
      int          k;
      int          rises;
      logic        sclk_d;
      bit          loaded;
      rst_n = 1'b0;
      set_stb = 1'b0;
      set_addr = '0;
      set_data = '0;
      pps = 1'b0;
      run_rx = 1'b0;
      run_tx = 1'b0;
      db_gpio_in = '0;
      repeat (5) @(negedge radio_clk);
      rst_n = 1'b1;
      @(negedge radio_clk);

      // Control registers
      for (int i = 0; i < 8; i++) begin
         m_test = get_rand(32);
         r = get_rand(8);
         m_misc = r[7:0];
         r = get_rand(1);
         m_lb = r[0];
         write_reg(radio_regs_pkg::sr_test, m_test);
         write_reg(radio_regs_pkg::sr_misc_outs, {24'd0, m_misc});
         write_reg(radio_regs_pkg::sr_loopback, {31'd0, m_lb});
         check_val("misc_outs", {56'd0, misc_outs}, {56'd0, m_misc});
         select_rb(radio_regs_pkg::rb_test, ref_rb(3'd3), 1);
         select_rb(radio_regs_pkg::rb_leds, ref_rb(3'd4), 1);
      end

      // DAC sync pulse
      write_reg(radio_regs_pkg::sr_dacsync, 32'd1);
      check_val("sync_dacs", {63'd0, sync_dacs}, 64'd1);
      @(negedge radio_clk);
      check_val("sync_dacs", {63'd0, sync_dacs}, 64'd0);

      // ATR banks over every run state
      for (int c = 0; c < 4; c++) begin
         for (int i = 0; i < 4; i++) begin
            db_w[i] = get_rand(32);
            r = get_rand(3);
            led_w[i] = r[2:0];
            write_reg(radio_regs_pkg::sr_gpio + 8'(i), db_w[i]);
            write_reg(radio_regs_pkg::sr_leds + 8'(i), {29'd0, led_w[i]});
         end
         m_db_in = get_rand(32);
         db_gpio_in = m_db_in;
         run_rx = c[0];
         run_tx = c[1];
         @(negedge radio_clk);
         check_val("db_gpio_out", {32'd0, db_gpio_out}, {32'd0, db_w[c]});
         check_val("leds", {61'd0, leds}, {61'd0, led_w[c]});
         select_rb(radio_regs_pkg::rb_spi_gpio, ref_rb(3'd0), 1);
         select_rb(radio_regs_pkg::rb_state, ref_rb(3'd5), 1);
      end

      // Direction word of the daughterboard bank
      r = get_rand(32);
      write_reg(radio_regs_pkg::sr_gpio + 8'd4, r);
      check_val("db_gpio_ddr", {32'd0, db_gpio_ddr}, {32'd0, r});

      // Immediate time load
      select_rb(radio_regs_pkg::rb_time, 64'd0, 0);
      hi = get_rand(32);
      lo = get_rand(32);
      write_reg(radio_regs_pkg::sr_time, hi);
      write_reg(radio_regs_pkg::sr_time + 8'd1, lo);
      r = get_rand(3);
      repeat (r) @(negedge radio_clk);
      t0 = {hi, lo} + 64'(r);
      check_val("rb_data", rb_data, t0);

      // PPS-timed load
      hi = get_rand(32);
      lo = get_rand(32);
      write_reg(radio_regs_pkg::sr_time, hi);
      write_reg(radio_regs_pkg::sr_time + 8'd2, lo);
      // Two writes later the counter has moved on by two
      t0 = t0 + 64'd2;
      check_val("vita_time", vita_time, t0);
      pps = 1'b1;
      k = 0;
      loaded = 0;
      while (k < 6 && !loaded) begin
         @(negedge radio_clk);
         k++;
         if (vita_time == {hi, lo})
            loaded = 1;
      end
      pps = 1'b0;
      if (!loaded || k < 2 || k > 4) begin
         errors++;
         $display("PPS load not seen within the synchronizer delay, %0d cycles", k);
      end
      select_rb(radio_regs_pkg::rb_time_pps, t0 + 64'(k - 1), 1);

      // SPI transfers with mosi looped to miso
      for (int i = 0; i < 4; i++) begin
         div = get_rand(2);
         len = get_rand(5);
         len = len + 1;
         mask = get_rand(8);
         edge_s = get_rand(1);
         data = get_rand(32);
         write_reg(radio_regs_pkg::sr_spi, div);
         write_reg(radio_regs_pkg::sr_spi + 8'd1, {17'd0, edge_s[0], len[5:0], mask[7:0]});
         write_reg(radio_regs_pkg::sr_spi + 8'd2, data);
         check_val("spi_ready", {63'd0, spi_ready}, 64'd0);
         rises = 0;
         sclk_d = 1'b0;
         while (!spi_ready) begin
            check_val("sen", {56'd0, sen}, {56'd0, ~mask[7:0]});
            if (sclk && !sclk_d)
               rises++;
            sclk_d = sclk;
            @(negedge radio_clk);
         end
         // One sclk rise per bit, and sclk parked low afterwards
         check_val("sclk", {63'd0, sclk}, 64'd0);
         check_val("sclk rising edges", 64'(rises), {32'd0, len});
         lmask = (len == 32) ? 32'hffff_ffff : ((32'd1 << len) - 1);
         select_rb(radio_regs_pkg::rb_spi_gpio, 64'd0, 0);
         check_val("spi_readback", {32'd0, rb_data[63:32] & lmask},
                   {32'd0, data >> (32 - len)});
      end

      // Radio number and an unused code
      select_rb(3'd6, ref_rb(3'd6), 1);
      select_rb(3'd7, ref_rb(3'd7), 1);
      repeat (2) @(negedge radio_clk);

      $display("errors: %0d", errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- verilog/gpio_atr.sv
// ####################
// ATR GPIO bank
// Output word follows the rx/tx run state
// ####################
module gpio_atr #(
   parameter int               WIDTH    = 32,
   parameter logic [WIDTH-1:0] DDR_INIT = '0
) (
   input  logic                             radio_clk,
   input  logic                             rst_n,
   input  logic                             wr,
   input  logic [radio_io_pkg::idx_w-1:0]   reg_idx,
   input  logic [radio_io_pkg::data_w-1:0]  reg_data,
   input  logic                             run_rx,
   input  logic                             run_tx,
   input  logic [WIDTH-1:0]                 gpio_in,
   output logic [WIDTH-1:0]                 gpio_out,
   output logic [WIDTH-1:0]                 gpio_ddr,
   output logic [WIDTH-1:0]                 gpio_readback
);

   logic [WIDTH-1:0] atr_idle, atr_rx, atr_tx, atr_fdx;
   logic [WIDTH-1:0] atr_sel;

   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         atr_idle <= '0;
         atr_rx   <= '0;
         atr_tx   <= '0;
         atr_fdx  <= '0;
         gpio_ddr <= DDR_INIT;
      end else if (wr) begin
         case (reg_idx)
            radio_regs_pkg::gpio_idle: atr_idle <= reg_data[WIDTH-1:0];
            radio_regs_pkg::gpio_rx:   atr_rx   <= reg_data[WIDTH-1:0];
            radio_regs_pkg::gpio_tx:   atr_tx   <= reg_data[WIDTH-1:0];
            radio_regs_pkg::gpio_fdx:  atr_fdx  <= reg_data[WIDTH-1:0];
            radio_regs_pkg::gpio_ddr:  gpio_ddr <= reg_data[WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // Pick the word for the current run state
   always_comb begin
      case ({run_tx, run_rx})
         2'b01:   atr_sel = atr_rx;
         2'b10:   atr_sel = atr_tx;
         2'b11:   atr_sel = atr_fdx;
         default: atr_sel = atr_idle;
      endcase
   end

   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         gpio_out      <= '0;
         gpio_readback <= '0;
      end else begin
         gpio_out      <= atr_sel;
         gpio_readback <= gpio_in;
      end
   end

endmodule

//--- verilog/radio_core.sv
// ####################
// Radio core
// Control block, ATR banks, timekeeper and SPI
// ####################
module radio_core (
   input  logic                                radio_clk,
   input  logic                                rst_n,
   input  logic                                set_stb,
   input  logic [radio_io_pkg::addr_w-1:0]     set_addr,
   input  logic [radio_io_pkg::data_w-1:0]     set_data,
   output logic [radio_io_pkg::rb_w-1:0]       rb_data,
   output logic                                spi_ready,
   output logic [radio_io_pkg::time_w-1:0]     vita_time,
   input  logic                                pps,
   input  logic                                run_rx,
   input  logic                                run_tx,
   input  logic [radio_io_pkg::db_gpio_w-1:0]  db_gpio_in,
   output logic [radio_io_pkg::db_gpio_w-1:0]  db_gpio_out,
   output logic [radio_io_pkg::db_gpio_w-1:0]  db_gpio_ddr,
   output logic [radio_io_pkg::led_w-1:0]      leds,
   output logic [radio_io_pkg::misc_w-1:0]     misc_outs,
   output logic                                sync_dacs,
   output logic [radio_io_pkg::sen_w-1:0]      sen,
   output logic                                sclk,
   output logic                                mosi,
   input  logic                                miso
);

   logic                                db_wr, led_wr, time_wr, spi_wr;
   logic [radio_io_pkg::idx_w-1:0]      reg_idx;
   logic [radio_io_pkg::data_w-1:0]     reg_data;
   logic [radio_io_pkg::data_w-1:0]     db_readback, spi_readback;
   logic [radio_io_pkg::time_w-1:0]     vita_time_pps;

   radio_ctrl ctrl0 (
      .radio_clk(radio_clk), .rst_n(rst_n),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .run_rx(run_rx), .run_tx(run_tx),
      .db_wr(db_wr), .led_wr(led_wr), .time_wr(time_wr), .spi_wr(spi_wr),
      .reg_idx(reg_idx), .reg_data(reg_data),
      .db_readback(db_readback), .spi_readback(spi_readback),
      .vita_time(vita_time), .vita_time_pps(vita_time_pps),
      .rb_data(rb_data), .misc_outs(misc_outs), .sync_dacs(sync_dacs)
   );

   gpio_atr #(.WIDTH(radio_io_pkg::db_gpio_w)) db_atr (
      .radio_clk(radio_clk), .rst_n(rst_n),
      .wr(db_wr), .reg_idx(reg_idx), .reg_data(reg_data),
      .run_rx(run_rx), .run_tx(run_tx), .gpio_in(db_gpio_in),
      .gpio_out(db_gpio_out), .gpio_ddr(db_gpio_ddr), .gpio_readback(db_readback)
   );

   // LED pins are always outputs, so ddr and readback stay inside
   gpio_atr #(.WIDTH(radio_io_pkg::led_w), .DDR_INIT('1)) led_atr (
      .radio_clk(radio_clk), .rst_n(rst_n),
      .wr(led_wr), .reg_idx(reg_idx), .reg_data(reg_data),
      .run_rx(run_rx), .run_tx(run_tx), .gpio_in(leds),
      .gpio_out(leds), .gpio_ddr(), .gpio_readback()
   );

   timekeeper time0 (
      .radio_clk(radio_clk), .rst_n(rst_n), .pps(pps),
      .wr(time_wr), .reg_idx(reg_idx), .reg_data(reg_data),
      .vita_time(vita_time), .vita_time_pps(vita_time_pps)
   );

   spi_core spi0 (
      .radio_clk(radio_clk), .rst_n(rst_n),
      .wr(spi_wr), .reg_idx(reg_idx), .reg_data(reg_data), .miso(miso),
      .spi_ready(spi_ready), .spi_readback(spi_readback),
      .sen(sen), .sclk(sclk), .mosi(mosi)
   );

endmodule

//--- verilog/radio_ctrl.sv
// ####################
// Radio control
// Settings decode, control registers, DAC sync
// and the readback selector
// ####################
module radio_ctrl (
   input  logic                              radio_clk,
   input  logic                              rst_n,
   input  logic                              set_stb,
   input  logic [radio_io_pkg::addr_w-1:0]   set_addr,
   input  logic [radio_io_pkg::data_w-1:0]   set_data,
   input  logic                              run_rx,
   input  logic                              run_tx,
   output logic                              db_wr,
   output logic                              led_wr,
   output logic                              time_wr,
   output logic                              spi_wr,
   output logic [radio_io_pkg::idx_w-1:0]    reg_idx,
   output logic [radio_io_pkg::data_w-1:0]   reg_data,
   input  logic [radio_io_pkg::data_w-1:0]   db_readback,
   input  logic [radio_io_pkg::data_w-1:0]   spi_readback,
   input  logic [radio_io_pkg::time_w-1:0]   vita_time,
   input  logic [radio_io_pkg::time_w-1:0]   vita_time_pps,
   output logic [radio_io_pkg::rb_w-1:0]     rb_data,
   output logic [radio_io_pkg::misc_w-1:0]   misc_outs,
   output logic                              sync_dacs
);

   logic                            hit_db, hit_led, hit_time, hit_spi;
   logic [radio_io_pkg::addr_w-1:0] base, offset;
   logic                            loopback;
   logic [radio_io_pkg::data_w-1:0] test;
   logic [radio_io_pkg::idx_w-1:0]  rb_sel;

   // True when addr falls in [first, first+last]
   function automatic logic in_range(input logic [7:0] addr, input logic [7:0] first,
                                     input logic [2:0] last);
      return (addr >= first) && (addr <= first + 8'(last));
   endfunction

   assign hit_db   = in_range(set_addr, radio_regs_pkg::sr_gpio, radio_regs_pkg::gpio_ddr);
   assign hit_led  = in_range(set_addr, radio_regs_pkg::sr_leds, radio_regs_pkg::gpio_ddr);
   assign hit_time = in_range(set_addr, radio_regs_pkg::sr_time, radio_regs_pkg::time_lo_pps);
   assign hit_spi  = in_range(set_addr, radio_regs_pkg::sr_spi, radio_regs_pkg::spi_data);

   always_comb begin
      base = '0;
      if (hit_db)
         base = radio_regs_pkg::sr_gpio;
      else if (hit_led)
         base = radio_regs_pkg::sr_leds;
      else if (hit_time)
         base = radio_regs_pkg::sr_time;
      else if (hit_spi)
         base = radio_regs_pkg::sr_spi;
   end

   // Register index relative to the block base
   assign offset   = set_addr - base;
   assign reg_idx  = offset[radio_io_pkg::idx_w-1:0];
   assign reg_data = set_data;

   assign db_wr   = set_stb & hit_db;
   assign led_wr  = set_stb & hit_led;
   assign time_wr = set_stb & hit_time;
   assign spi_wr  = set_stb & hit_spi;

   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_dacs <= 1'b0;
         loopback  <= 1'b0;
         test      <= '0;
         misc_outs <= '0;
         rb_sel    <= '0;
      end else begin
         // Any write to the sync address fires one pulse
         sync_dacs <= set_stb && (set_addr == radio_regs_pkg::sr_dacsync);
         if (set_stb) begin
            case (set_addr)
               radio_regs_pkg::sr_loopback:  loopback  <= set_data[0];
               radio_regs_pkg::sr_test:      test      <= set_data;
               radio_regs_pkg::sr_misc_outs: misc_outs <= set_data[radio_io_pkg::misc_w-1:0];
               radio_regs_pkg::sr_readback:  rb_sel    <= set_data[radio_io_pkg::idx_w-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (rb_sel)
         radio_regs_pkg::rb_spi_gpio:  rb_data = {spi_readback, db_readback};
         radio_regs_pkg::rb_time:      rb_data = vita_time;
         radio_regs_pkg::rb_time_pps:  rb_data = vita_time_pps;
         radio_regs_pkg::rb_test:      rb_data = {31'd0, loopback, test};
         radio_regs_pkg::rb_leds:      rb_data = {55'd0, loopback, misc_outs};
         radio_regs_pkg::rb_state:     rb_data = {62'd0, run_tx, run_rx};
         radio_regs_pkg::rb_radio_num: rb_data = {32'd0, radio_regs_pkg::radio_num};
         default:                      rb_data = '0;
      endcase
   end

endmodule

//--- verilog/radio_io_pkg.sv
// ####################
// Radio I/O widths
// Bus, readback, time and SPI field sizes
// ####################
package radio_io_pkg;

   // Settings bus and readback
   localparam int addr_w = 8;
   localparam int data_w = 32;
   localparam int rb_w   = 64;
   localparam int idx_w  = 3;

   localparam int time_w = 64;

   // SPI master
   localparam int sen_w     = 8;
   localparam int spi_len_w = 6;
   localparam int div_w     = 16;
   // Config word layout: mask in the low bits, then bit count, then edge select
   localparam int spi_len_lsb  = 8;
   localparam int spi_edge_bit = 14;

   // Pin banks
   localparam int db_gpio_w = 32;
   localparam int led_w     = 3;
   localparam int misc_w    = 8;

endpackage

//--- verilog/radio_regs_pkg.sv
// ####################
// Radio register map
// Settings-bus addresses and register indices
// ####################
package radio_regs_pkg;

   // Settings-bus base addresses
   localparam logic [7:0] sr_dacsync   = 8'd5;
   localparam logic [7:0] sr_loopback  = 8'd6;
   localparam logic [7:0] sr_test      = 8'd7;
   localparam logic [7:0] sr_spi       = 8'd8;
   localparam logic [7:0] sr_gpio      = 8'd16;
   localparam logic [7:0] sr_misc_outs = 8'd24;
   localparam logic [7:0] sr_readback  = 8'd32;
   localparam logic [7:0] sr_time      = 8'd128;
   localparam logic [7:0] sr_leds      = 8'd196;

   // ATR bank registers
   localparam logic [2:0] gpio_idle = 3'd0;
   localparam logic [2:0] gpio_rx   = 3'd1;
   localparam logic [2:0] gpio_tx   = 3'd2;
   localparam logic [2:0] gpio_fdx  = 3'd3;
   localparam logic [2:0] gpio_ddr  = 3'd4;

   // Timekeeper registers
   localparam logic [2:0] time_hi     = 3'd0;
   localparam logic [2:0] time_lo_now = 3'd1;
   localparam logic [2:0] time_lo_pps = 3'd2;

   // SPI registers
   localparam logic [2:0] spi_divider = 3'd0;
   localparam logic [2:0] spi_config  = 3'd1;
   localparam logic [2:0] spi_data    = 3'd2;

   // Readback selector codes
   localparam logic [2:0] rb_spi_gpio  = 3'd0;
   localparam logic [2:0] rb_time      = 3'd1;
   localparam logic [2:0] rb_time_pps  = 3'd2;
   localparam logic [2:0] rb_test      = 3'd3;
   localparam logic [2:0] rb_leds      = 3'd4;
   localparam logic [2:0] rb_state     = 3'd5;
   localparam logic [2:0] rb_radio_num = 3'd6;

   localparam logic [31:0] radio_num = 32'd0;

endpackage

//--- verilog/spi_core.sv
// ####################
// SPI master
// Sends the top n bits of the data word MSB first,
// shifts n received bits into the readback word
// ####################
module spi_core (
   input  logic                                radio_clk,
   input  logic                                rst_n,
   input  logic                                wr,
   input  logic [radio_io_pkg::idx_w-1:0]      reg_idx,
   input  logic [radio_io_pkg::data_w-1:0]     reg_data,
   input  logic                                miso,
   output logic                                spi_ready,
   output logic [radio_io_pkg::data_w-1:0]     spi_readback,
   output logic [radio_io_pkg::sen_w-1:0]      sen,
   output logic                                sclk,
   output logic                                mosi
);

   localparam int dw = radio_io_pkg::data_w;

   logic [radio_io_pkg::div_w-1:0]     divider, clk_cnt;
   logic [radio_io_pkg::sen_w-1:0]     sen_mask;
   logic [radio_io_pkg::spi_len_w-1:0] num_bits, bits_left;
   logic                               edge_sel;
   logic                               busy, first, tick;
   logic [dw-1:0]                      tx_shift;

   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         divider  <= '0;
         sen_mask <= '0;
         num_bits <= '0;
         edge_sel <= 1'b0;
      end else if (wr) begin
         if (reg_idx == radio_regs_pkg::spi_divider)
            divider <= reg_data[radio_io_pkg::div_w-1:0];
         if (reg_idx == radio_regs_pkg::spi_config) begin
            sen_mask <= reg_data[radio_io_pkg::sen_w-1:0];
            num_bits <= reg_data[radio_io_pkg::spi_len_lsb +: radio_io_pkg::spi_len_w];
            edge_sel <= reg_data[radio_io_pkg::spi_edge_bit];
         end
      end
   end

   // Half an sclk period is divider+1 cycles
   assign tick      = busy && (clk_cnt == divider);
   assign spi_ready = ~busy;
   assign mosi      = tx_shift[dw-1];

   // edge_sel 0: launch on falling, sample on rising
   // edge_sel 1: launch on rising, sample on falling
   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         busy         <= 1'b0;
         first        <= 1'b0;
         clk_cnt      <= '0;
         bits_left    <= '0;
         sclk         <= 1'b0;
         sen          <= '1;
         tx_shift     <= '0;
         spi_readback <= '0;
      end else if (wr && reg_idx == radio_regs_pkg::spi_data && !busy) begin
         busy      <= 1'b1;
         first     <= 1'b1;
         clk_cnt   <= '0;
         bits_left <= num_bits;
         sclk      <= 1'b0;
         // Chip selects are active low
         sen       <= ~sen_mask;
         tx_shift  <= reg_data;
      end else if (busy) begin
         if (!tick) begin
            clk_cnt <= clk_cnt + 1'b1;
         end else begin
            clk_cnt <= '0;
            sclk    <= ~sclk;
            if (!sclk) begin
               // Rising edge
               first <= 1'b0;
               if (!edge_sel)
                  spi_readback <= {spi_readback[dw-2:0], miso};
               else if (!first)
                  tx_shift <= tx_shift << 1;
            end else begin
               // Falling edge closes one bit
               if (edge_sel)
                  spi_readback <= {spi_readback[dw-2:0], miso};
               else
                  tx_shift <= tx_shift << 1;
               bits_left <= bits_left - 1'b1;
               if (bits_left == 1) begin
                  busy <= 1'b0;
                  sen  <= '1;
               end
            end
         end
      end
   end

endmodule

//--- verilog/timekeeper.sv
// ####################
// Timekeeper
// 64-bit sample time with PPS-timed load
// and last-PPS capture
// ####################
module timekeeper (
   input  logic                             radio_clk,
   input  logic                             rst_n,
   input  logic                             pps,
   input  logic                             wr,
   input  logic [radio_io_pkg::idx_w-1:0]   reg_idx,
   input  logic [radio_io_pkg::data_w-1:0]  reg_data,
   output logic [radio_io_pkg::time_w-1:0]  vita_time,
   output logic [radio_io_pkg::time_w-1:0]  vita_time_pps
);

   logic [radio_io_pkg::data_w-1:0] time_hi_reg;
   logic [radio_io_pkg::time_w-1:0] pps_load;
   logic                            armed;
   logic                            pps_s1, pps_s2, pps_d;
   logic                            pps_edge;

   // Two-flop synchronizer, then rising-edge detect
   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
      end else begin
         pps_s1 <= pps;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 & ~pps_d;

   always_ff @(posedge radio_clk) begin
      if (wr && reg_idx == radio_regs_pkg::time_lo_pps)
         pps_load <= {time_hi_reg, reg_data};
   end

   always_ff @(posedge radio_clk or negedge rst_n) begin
      if (!rst_n) begin
         time_hi_reg   <= '0;
         armed         <= 1'b0;
         vita_time     <= '0;
         vita_time_pps <= '0;
      end else begin
         if (wr && reg_idx == radio_regs_pkg::time_hi)
            time_hi_reg <= reg_data;
         if (pps_edge)
            vita_time_pps <= vita_time;
         // Immediate load wins over a pending PPS load
         if (wr && reg_idx == radio_regs_pkg::time_lo_now) begin
            vita_time <= {time_hi_reg, reg_data};
         end else if (pps_edge && armed) begin
            vita_time <= pps_load;
         end else begin
            vita_time <= vita_time + 1'b1;
         end
         if (wr && reg_idx == radio_regs_pkg::time_lo_pps)
            armed <= 1'b1;
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

endmodule
